/* source/fft_pkg.sv */
`default_nettype none

package fft_pkg;

    // width of one real or imaginary part, q1.15
    localparam int sample_w = 16;

    // sample address into one memory bank
    localparam int addr_w = 5;

    localparam int n_points = 32;   // transform size
    localparam int n_stages = 5;    // log2(n_points) radix-2 stages

    // index into the 16 entry twiddle table, w_k for k = 0..n_points/2-1
    localparam int twiddle_w = 4;

    // register stages inside the butterfly, read data in to x/y out
    // the agu adds one more cycle for the memory read when it delays write addresses
    localparam int bfly_latency = 3;

endpackage

`default_nettype wire

/* source/fft_mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one client's view of the ping-pong data memory
interface fft_mem_if #(
    parameter int addr_w   = fft_pkg::addr_w,
    parameter int sample_w = fft_pkg::sample_w
);

    logic                       rd_bank;    // bank read this cycle, writes hit the other one
    logic [addr_w-1:0]          rd_g_addr;  // upper leg of the butterfly
    logic [addr_w-1:0]          rd_h_addr;  // lower leg
    logic signed [sample_w-1:0] rd_g_re;    // read data, one cycle after the address
    logic signed [sample_w-1:0] rd_g_im;
    logic signed [sample_w-1:0] rd_h_re;
    logic signed [sample_w-1:0] rd_h_im;

    logic                       wr_en;      // both write ports fire together
    logic [addr_w-1:0]          wr_g_addr;
    logic [addr_w-1:0]          wr_h_addr;
    logic signed [sample_w-1:0] wr_g_re;
    logic signed [sample_w-1:0] wr_g_im;
    logic signed [sample_w-1:0] wr_h_re;
    logic signed [sample_w-1:0] wr_h_im;

    modport client (
        output rd_bank, rd_g_addr, rd_h_addr,
        input  rd_g_re, rd_g_im, rd_h_re, rd_h_im,
        output wr_en, wr_g_addr, wr_h_addr,
        output wr_g_re, wr_g_im, wr_h_re, wr_h_im
    );

    modport memory (
        input  rd_bank, rd_g_addr, rd_h_addr,
        output rd_g_re, rd_g_im, rd_h_re, rd_h_im,
        input  wr_en, wr_g_addr, wr_h_addr,
        input  wr_g_re, wr_g_im, wr_h_re, wr_h_im
    );

endinterface

`default_nettype wire

/* source/fft_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_agu #(
    parameter int addr_w       = fft_pkg::addr_w,
    parameter int twiddle_w    = fft_pkg::twiddle_w,
    parameter int n_points     = fft_pkg::n_points,
    parameter int n_stages     = fft_pkg::n_stages,
    parameter int bfly_latency = fft_pkg::bfly_latency
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 start_fft,
    output logic                 busy,
    output logic                 done,
    output logic [twiddle_w-1:0] twiddle_idx,  // lines up with the read data
    fft_mem_if.client            mem
);

    localparam int n_bfly    = n_points / 2;         // butterflies per stage
    localparam int wb_delay  = 1 + bfly_latency;     // memory read plus butterfly pipe
    localparam int stage_len = n_bfly + wb_delay;    // issue cycles then drain
    localparam int cnt_w     = $clog2(stage_len);
    localparam int stage_w   = $clog2(n_stages);

    logic [stage_w-1:0]   stage;
    logic [cnt_w-1:0]     cnt;          // cycle within the stage
    logic                 issue;        // a butterfly read goes out this cycle
    logic                 last_cycle;
    logic [addr_w-1:0]    g_addr;
    logic [addr_w-1:0]    h_addr;
    logic [twiddle_w-1:0] tw_next;

    logic [wb_delay-1:0]  wr_pipe;      // write enable delay line
    logic [addr_w-1:0]    g_pipe [wb_delay];
    logic [addr_w-1:0]    h_pipe [wb_delay];

    assign issue      = busy && (cnt < cnt_w'(n_bfly));
    assign last_cycle = (cnt == cnt_w'(stage_len - 1));

    // butterfly j of stage s: insert a zero at bit s of j to get g, h = g + 2^s
    always_comb begin
        logic [addr_w-1:0] j;
        logic [addr_w-1:0] span;
        logic [addr_w-1:0] pos;
        logic [addr_w-1:0] tw_full;
        j       = {1'b0, cnt[addr_w-2:0]};
        span    = addr_w'(1) << stage;
        pos     = j & (span - addr_w'(1));            // j mod 2^s
        g_addr  = ((j >> stage) << (stage + 1)) | pos;
        h_addr  = g_addr | span;
        tw_full = pos << (twiddle_w - int'(stage));   // k = (j mod 2^s) * 2^(4-s)
        tw_next = tw_full[twiddle_w-1:0];
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            stage <= '0;
            cnt   <= '0;
        end else if (!busy) begin
            if (start_fft) begin
                busy  <= 1'b1;
                done  <= 1'b0;  // done holds until the next start
                stage <= '0;
                cnt   <= '0;
            end
        end else if (last_cycle) begin
            cnt <= '0;
            if (stage == stage_w'(n_stages - 1)) begin
                busy <= 1'b0;   // last write-back lands on this same edge
                done <= 1'b1;
            end else begin
                stage <= stage + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_pipe <= '0;  // no stray write-back after an abort
        end else begin
            wr_pipe <= {wr_pipe[wb_delay-2:0], issue};
        end
    end

    always_ff @(posedge clock) begin
        g_pipe[0] <= g_addr;
        h_pipe[0] <= h_addr;
        for (int i = 1; i < wb_delay; i++) begin
            g_pipe[i] <= g_pipe[i-1];
            h_pipe[i] <= h_pipe[i-1];
        end
        twiddle_idx <= tw_next;  // same edge as the memory read register
    end

    assign mem.rd_bank   = stage[0];  // stage s reads bank s mod 2
    assign mem.rd_g_addr = g_addr;
    assign mem.rd_h_addr = h_addr;
    assign mem.wr_en     = wr_pipe[wb_delay-1];
    assign mem.wr_g_addr = g_pipe[wb_delay-1];
    assign mem.wr_h_addr = h_pipe[wb_delay-1];

endmodule

`default_nettype wire

/* source/fft_twiddle_rom.sv */
`timescale 1ns/1ps
`default_nettype none

// w_k = cos(pi*k/16) - j*sin(pi*k/16), only the sine magnitude is stored
// the butterfly applies the minus sign itself
module fft_twiddle_rom #(
    parameter int sample_w  = fft_pkg::sample_w,
    parameter int twiddle_w = fft_pkg::twiddle_w
) (
    input  logic [twiddle_w-1:0]       twiddle_idx,
    output logic signed [sample_w-1:0] w_re,
    output logic signed [sample_w-1:0] w_im
);

    always_comb begin
        case (twiddle_idx)
            4'd0:  {w_re, w_im} = {16'h7fff, 16'h0000};  // cos clipped to max q1.15
            4'd1:  {w_re, w_im} = {16'h7d8a, 16'h18f9};
            4'd2:  {w_re, w_im} = {16'h7642, 16'h30fc};
            4'd3:  {w_re, w_im} = {16'h6a6e, 16'h471d};
            4'd4:  {w_re, w_im} = {16'h5a82, 16'h5a82};  // pi/4
            4'd5:  {w_re, w_im} = {16'h471d, 16'h6a6e};
            4'd6:  {w_re, w_im} = {16'h30fc, 16'h7642};
            4'd7:  {w_re, w_im} = {16'h18f9, 16'h7d8a};
            4'd8:  {w_re, w_im} = {16'h0000, 16'h7fff};  // -j
            4'd9:  {w_re, w_im} = {16'he707, 16'h7d8a};
            4'd10: {w_re, w_im} = {16'hcf04, 16'h7642};
            4'd11: {w_re, w_im} = {16'hb8e3, 16'h6a6e};
            4'd12: {w_re, w_im} = {16'ha57e, 16'h5a82};
            4'd13: {w_re, w_im} = {16'h9592, 16'h471d};
            4'd14: {w_re, w_im} = {16'h89be, 16'h30fc};
            4'd15: {w_re, w_im} = {16'h8276, 16'h18f9};
        endcase
    end

endmodule

`default_nettype wire

/* source/fft_butterfly.sv */
`timescale 1ns/1ps
`default_nettype none

// x = (a + w*b) / 2, y = (a - w*b) / 2 with w = w_re - j*w_im
module fft_butterfly #(
    parameter int sample_w = fft_pkg::sample_w
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic signed [sample_w-1:0] a_re,
    input  logic signed [sample_w-1:0] a_im,
    input  logic signed [sample_w-1:0] b_re,
    input  logic signed [sample_w-1:0] b_im,
    input  logic signed [sample_w-1:0] w_re,
    input  logic signed [sample_w-1:0] w_im,
    output logic signed [sample_w-1:0] x_re,
    output logic signed [sample_w-1:0] x_im,
    output logic signed [sample_w-1:0] y_re,
    output logic signed [sample_w-1:0] y_im
);

    localparam int prod_w = 2 * sample_w;   // full q2.30 product
    localparam int t_w    = sample_w + 2;   // |w*b| can reach sqrt(2) full scale

    logic signed [prod_w-1:0]   p_rr, p_ii, p_ir, p_ri;  // stage 1
    logic signed [sample_w-1:0] a1_re, a1_im;
    logic signed [prod_w:0]     s_re, s_im;              // product sums, one guard bit
    logic signed [t_w-1:0]      t_re, t_im;              // stage 2
    logic signed [sample_w-1:0] a2_re, a2_im;
    logic signed [t_w:0]        u_x_re, u_x_im, u_y_re, u_y_im;

    assign s_re = p_rr + p_ii;   // br*wr + bi*wi
    assign s_im = p_ir - p_ri;   // bi*wr - br*wi

    assign u_x_re = a2_re + t_re;
    assign u_x_im = a2_im + t_im;
    assign u_y_re = a2_re - t_re;
    assign u_y_im = a2_im - t_im;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            p_rr  <= '0;
            p_ii  <= '0;
            p_ir  <= '0;
            p_ri  <= '0;
            a1_re <= '0;
            a1_im <= '0;
            t_re  <= '0;
            t_im  <= '0;
            a2_re <= '0;
            a2_im <= '0;
            x_re  <= '0;
            x_im  <= '0;
            y_re  <= '0;
            y_im  <= '0;
        end else begin
            p_rr  <= b_re * w_re;   // four real multiplies
            p_ii  <= b_im * w_im;
            p_ir  <= b_im * w_re;
            p_ri  <= b_re * w_im;
            a1_re <= a_re;
            a1_im <= a_im;
            // back to q1.15, arithmetic shift floors toward -inf
            t_re  <= t_w'(s_re >>> (sample_w - 1));
            t_im  <= t_w'(s_im >>> (sample_w - 1));
            a2_re <= a1_re;
            a2_im <= a1_im;
            x_re  <= sample_w'(u_x_re >>> 1);   // halve every stage, keep low bits
            x_im  <= sample_w'(u_x_im >>> 1);
            y_re  <= sample_w'(u_y_re >>> 1);
            y_im  <= sample_w'(u_y_im >>> 1);
        end
    end

endmodule

`default_nettype wire

/* source/fft_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_mem_arbiter #(
    parameter int addr_w   = fft_pkg::addr_w,
    parameter int sample_w = fft_pkg::sample_w
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       busy,
    fft_mem_if.memory                  eng,
    fft_mem_if.memory                  host,
    fft_mem_if.client                  dmem,
    input  logic                       load_write,
    input  logic [addr_w-1:0]          load_addr,
    input  logic signed [sample_w-1:0] load_re,
    input  logic signed [sample_w-1:0] load_im,
    input  logic [addr_w-1:0]          read_addr,
    output logic signed [sample_w-1:0] out_re,
    output logic signed [sample_w-1:0] out_im
);

    logic [addr_w-1:0]          load_rev;     // bit-reversed load address
    logic signed [sample_w-1:0] hold_re;      // last bin seen by the host
    logic signed [sample_w-1:0] hold_im;

    always_comb begin
        for (int i = 0; i < addr_w; i++) begin
            load_rev[i] = load_addr[addr_w-1-i];
        end
    end

    // engine owns the memory for the whole run, host loads are dropped then
    assign dmem.rd_bank   = busy ? eng.rd_bank   : 1'b1;  // host reads bank 1, loads bank 0
    assign dmem.rd_g_addr = busy ? eng.rd_g_addr : read_addr;
    assign dmem.rd_h_addr = busy ? eng.rd_h_addr : read_addr;
    assign dmem.wr_en     = busy ? eng.wr_en     : load_write;
    assign dmem.wr_g_addr = busy ? eng.wr_g_addr : load_rev;
    assign dmem.wr_h_addr = busy ? eng.wr_h_addr : load_rev;  // same word twice
    assign dmem.wr_g_re   = busy ? eng.wr_g_re   : load_re;
    assign dmem.wr_g_im   = busy ? eng.wr_g_im   : load_im;
    assign dmem.wr_h_re   = busy ? eng.wr_h_re   : load_re;
    assign dmem.wr_h_im   = busy ? eng.wr_h_im   : load_im;

    // read data fans out to both clients
    assign eng.rd_g_re  = dmem.rd_g_re;
    assign eng.rd_g_im  = dmem.rd_g_im;
    assign eng.rd_h_re  = dmem.rd_h_re;
    assign eng.rd_h_im  = dmem.rd_h_im;
    assign host.rd_g_re = dmem.rd_g_re;
    assign host.rd_g_im = dmem.rd_g_im;
    assign host.rd_h_re = dmem.rd_h_re;
    assign host.rd_h_im = dmem.rd_h_im;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hold_re <= '0;
            hold_im <= '0;
        end else if (!busy) begin
            hold_re <= host.rd_g_re;
            hold_im <= host.rd_g_im;
        end
    end

    // bin shows one cycle after read_addr, frozen while the engine runs
    assign out_re = busy ? hold_re : host.rd_g_re;
    assign out_im = busy ? hold_im : host.rd_g_im;

endmodule

`default_nettype wire

/* source/fft_dmem.sv */
`timescale 1ns/1ps
`default_nettype none

// ping-pong data memory, each word is {re, im}
// reads come from rd_bank, both write ports go to the other bank
module fft_dmem #(
    parameter int addr_w   = fft_pkg::addr_w,
    parameter int sample_w = fft_pkg::sample_w,
    parameter int n_points = fft_pkg::n_points
) (
    input  logic      clock,
    fft_mem_if.memory mem
);

    localparam int word_w = 2 * sample_w;

    logic [word_w-1:0] bank0 [n_points];   // loads land here, even stages read it
    logic [word_w-1:0] bank1 [n_points];   // odd stages read it, final bins end here
    logic [addr_w-1:0] g_rd;
    logic [addr_w-1:0] h_rd;

    assign g_rd = mem.rd_g_addr;
    assign h_rd = mem.rd_h_addr;

    // registered read ports, one cycle latency
    always_ff @(posedge clock) begin
        if (mem.rd_bank) begin
            {mem.rd_g_re, mem.rd_g_im} <= bank1[g_rd];
            {mem.rd_h_re, mem.rd_h_im} <= bank1[h_rd];
        end else begin
            {mem.rd_g_re, mem.rd_g_im} <= bank0[g_rd];
            {mem.rd_h_re, mem.rd_h_im} <= bank0[h_rd];
        end
    end

    // never the bank being read, so no read/write collision
    always_ff @(posedge clock) begin
        if (mem.wr_en) begin
            if (mem.rd_bank) begin
                bank0[mem.wr_g_addr] <= {mem.wr_g_re, mem.wr_g_im};
                bank0[mem.wr_h_addr] <= {mem.wr_h_re, mem.wr_h_im};
            end else begin
                bank1[mem.wr_g_addr] <= {mem.wr_g_re, mem.wr_g_im};
                bank1[mem.wr_h_addr] <= {mem.wr_h_re, mem.wr_h_im};
            end
        end
    end

endmodule

`default_nettype wire

/* source/fft_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_top #(
    parameter int sample_w     = fft_pkg::sample_w,
    parameter int addr_w       = fft_pkg::addr_w,
    parameter int n_points     = fft_pkg::n_points,
    parameter int n_stages     = fft_pkg::n_stages,
    parameter int twiddle_w    = fft_pkg::twiddle_w,
    parameter int bfly_latency = fft_pkg::bfly_latency
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       start_fft,
    input  logic                       load_write,
    input  logic [addr_w-1:0]          load_addr,   // natural order
    input  logic signed [sample_w-1:0] load_re,
    input  logic signed [sample_w-1:0] load_im,
    input  logic [addr_w-1:0]          read_addr,   // bin number
    output logic                       busy,
    output logic                       done,
    output logic signed [sample_w-1:0] out_re,
    output logic signed [sample_w-1:0] out_im
);

    logic [twiddle_w-1:0]       twiddle_idx;
    logic signed [sample_w-1:0] w_re;
    logic signed [sample_w-1:0] w_im;

    fft_mem_if #(.addr_w(addr_w), .sample_w(sample_w)) eng_mem ();
    fft_mem_if #(.addr_w(addr_w), .sample_w(sample_w)) host_mem ();
    fft_mem_if #(.addr_w(addr_w), .sample_w(sample_w)) dmem_bus ();

    fft_agu #(
        .addr_w       (addr_w),
        .twiddle_w    (twiddle_w),
        .n_points     (n_points),
        .n_stages     (n_stages),
        .bfly_latency (bfly_latency)
    ) i_agu (
        .clock       (clock),
        .rst_n       (rst_n),
        .start_fft   (start_fft),
        .busy        (busy),
        .done        (done),
        .twiddle_idx (twiddle_idx),
        .mem         (eng_mem.client)
    );

    fft_twiddle_rom #(.sample_w(sample_w), .twiddle_w(twiddle_w)) i_twiddle_rom (
        .twiddle_idx (twiddle_idx),
        .w_re        (w_re),
        .w_im        (w_im)
    );

    // read pair in, write-back pair out, the agu lines up the addresses
    fft_butterfly #(.sample_w(sample_w)) i_butterfly (
        .clock (clock),
        .rst_n (rst_n),
        .a_re  (eng_mem.rd_g_re),
        .a_im  (eng_mem.rd_g_im),
        .b_re  (eng_mem.rd_h_re),
        .b_im  (eng_mem.rd_h_im),
        .w_re  (w_re),
        .w_im  (w_im),
        .x_re  (eng_mem.wr_g_re),
        .x_im  (eng_mem.wr_g_im),
        .y_re  (eng_mem.wr_h_re),
        .y_im  (eng_mem.wr_h_im)
    );

    fft_mem_arbiter #(.addr_w(addr_w), .sample_w(sample_w)) i_mem_arbiter (
        .clock      (clock),
        .rst_n      (rst_n),
        .busy       (busy),
        .eng        (eng_mem.memory),
        .host       (host_mem.memory),
        .dmem       (dmem_bus.client),
        .load_write (load_write),
        .load_addr  (load_addr),
        .load_re    (load_re),
        .load_im    (load_im),
        .read_addr  (read_addr),
        .out_re     (out_re),
        .out_im     (out_im)
    );

    fft_dmem #(.addr_w(addr_w), .sample_w(sample_w), .n_points(n_points)) i_dmem (
        .clock (clock),
        .mem   (dmem_bus.memory)
    );

endmodule

`default_nettype wire

/* dv/fft_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_tb;

    localparam int sample_w = fft_pkg::sample_w;
    localparam int addr_w   = fft_pkg::addr_w;
    localparam int n_points = fft_pkg::n_points;
    localparam int n_stages = fft_pkg::n_stages;
    localparam real pi      = 3.14159265358979;

    // one {re, im} word per bin
    typedef logic [n_points-1:0][2*sample_w-1:0] bins_t;

    logic                       clock;
    logic                       rst_n;
    logic                       start_fft;
    logic                       load_write;
    logic [addr_w-1:0]          load_addr;
    logic signed [sample_w-1:0] load_re;
    logic signed [sample_w-1:0] load_im;
    logic [addr_w-1:0]          read_addr;
    logic                       busy;
    logic                       done;
    logic signed [sample_w-1:0] out_re;
    logic signed [sample_w-1:0] out_im;

    integer seed = 32'h1cdf_6442;
    int     n_checks = 0;
    int     n_errors = 0;
    bit     aborted = 1'b0;     // set once a wait times out
    bins_t  expected;       // bins the checker compares against
    logic   check_done;
    event   check_start;

    fft_top i_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .start_fft  (start_fft),
        .load_write (load_write),
        .load_addr  (load_addr),
        .load_re    (load_re),
        .load_im    (load_im),
        .read_addr  (read_addr),
        .busy       (busy),
        .done       (done),
        .out_re     (out_re),
        .out_im     (out_im)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;   // 8 ns period

    // round to q1.15 with +1.0 clipped to the largest code
    function automatic longint q15_round(real x);
        real    scaled;
        longint v;
        scaled = x * 32768.0;
        if (scaled >= 0.0) begin
            v = $rtoi(scaled + 0.5);
        end else begin
            v = -$rtoi(-scaled + 0.5);
        end
        if (v > 32767) begin
            v = 32767;
        end
        return v;
    endfunction

    // keep the low 16 bits and sign-extend them again
    function automatic longint to_sample(longint v);
        logic signed [sample_w-1:0] t;
        t = v[sample_w-1:0];
        return longint'(t);
    endfunction

    // integer dit fft where each butterfly halves its outputs
    function automatic bins_t fft_ref(bins_t x);
        longint re [n_points];
        longint im [n_points];
        longint wr, wi, ar, ai, br, bi, tr, ti;
        int     span, pos, g, h, k, rev;
        bins_t  y;
        for (int i = 0; i < n_points; i++) begin
            rev = 0;
            for (int b = 0; b < addr_w; b++) begin
                if ((i >> b) & 1) begin
                    rev = rev | (1 << (addr_w - 1 - b));  // mirror the index bits
                end
            end
            re[rev] = $signed(x[i][2*sample_w-1:sample_w]);
            im[rev] = $signed(x[i][sample_w-1:0]);
        end
        for (int s = 0; s < n_stages; s++) begin
            span = 1 << s;
            for (int j = 0; j < n_points / 2; j++) begin
                pos = j % span;
                g   = (j / span) * 2 * span + pos;
                h   = g + span;
                k   = pos * (n_points / 2 / span);  // twiddle index 0..15
                wr  = q15_round($cos(pi * k / 16.0));
                wi  = q15_round($sin(pi * k / 16.0));  // w = wr - j*wi
                ar  = re[g];
                ai  = im[g];
                br  = re[h];
                bi  = im[h];
                tr  = (br * wr + bi * wi) >>> 15;
                ti  = (bi * wr - br * wi) >>> 15;
                re[g] = to_sample((ar + tr) >>> 1);
                im[g] = to_sample((ai + ti) >>> 1);
                re[h] = to_sample((ar - tr) >>> 1);
                im[h] = to_sample((ai - ti) >>> 1);
            end
        end
        for (int i = 0; i < n_points; i++) begin
            y[i] = {re[i][sample_w-1:0], im[i][sample_w-1:0]};
        end
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // half scale random re and im samples
    task automatic make_random(output bins_t data);
        logic [31:0] rnd;
        for (int i = 0; i < n_points; i++) begin
            rnd = $random(seed);
            data[i] = {rnd[31], rnd[31:17], rnd[15], rnd[15:1]};
        end
    endtask

    task automatic load_samples(input bins_t data);
        for (int i = 0; i < n_points; i++) begin
            load_write = 1'b1;
            load_addr  = addr_w'(i);  // natural order that the dut reverses
            load_re    = data[i][2*sample_w-1:sample_w];
            load_im    = data[i][sample_w-1:0];
            next_cycle();
        end
        load_write = 1'b0;
    endtask

    task automatic pulse_start();
        start_fft = 1'b1;
        next_cycle();
        start_fft = 1'b0;
        check_value("busy", busy, 32'h1);   // raised on the start edge
        check_value("done", done, 32'h0);   // old done cleared
    endtask

    // garbage writes while the engine owns the memory
    task automatic inject_loads(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd        = $random(seed);
            load_write = 1'b1;
            load_addr  = rnd[addr_w-1:0];
            load_re    = rnd[31:16];
            load_im    = rnd[15:0];
            next_cycle();
        end
        load_write = 1'b0;
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        if (!aborted) begin
            while (done !== 1'b1 && cycles < limit) begin
                check_value("busy", busy, 32'h1);   // high for the whole run
                next_cycle();
                cycles++;
            end
            if (done !== 1'b1) begin
                n_errors++;
                aborted = 1'b1;
                $display("timeout: done did not rise within %0d cycles", limit);
            end else begin
                check_value("busy", busy, 32'h0);   // falls on the done edge
            end
        end
    endtask

    // hand the bins to the checker and wait for it
    task automatic compare_bins(input int limit);
        int cycles;
        cycles = 0;
        if (!aborted) begin
            check_done = 1'b0;
            -> check_start;
            while (!check_done && cycles < limit) begin
                @(negedge clock);
                cycles++;
            end
            if (!check_done) begin
                n_errors++;
                aborted = 1'b1;
                $display("timeout: bin readback did not finish within %0d cycles", limit);
            end else begin
                next_cycle();
            end
        end
    endtask

    task automatic run_and_check(input bins_t data);
        if (!aborted) begin
            load_samples(data);
            expected = fft_ref(data);
            pulse_start();
            wait_for_done(200);
            compare_bins(200);
            if (!aborted) begin
                check_value("done", done, 32'h1);   // still high long after the run
                check_value("busy", busy, 32'h0);
            end
        end
    endtask

    // reads every bin with one request per two cycles
    initial begin : bin_checker
        read_addr = '0;
        forever begin
            @(check_start);
            for (int i = 0; i < n_points; i++) begin
                next_cycle();
                read_addr = addr_w'(i);
                next_cycle();   // registered read has landed
                check_value($sformatf("out_re[%0d]", i), $unsigned(out_re),
                            expected[i][2*sample_w-1:sample_w]);
                check_value($sformatf("out_im[%0d]", i), $unsigned(out_im),
                            expected[i][sample_w-1:0]);
            end
            check_done = 1'b1;
        end
    end

    initial begin : stimulus
        bins_t data;
        rst_n      = 1'b0;
        start_fft  = 1'b0;
        load_write = 1'b0;
        load_addr  = '0;
        load_re    = '0;
        load_im    = '0;
        check_done = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        check_value("busy", busy, 32'h0);
        check_value("done", done, 32'h0);

        // impulse gives every bin near 0x03ff
        data    = '0;
        data[0] = {16'h7fff, 16'h0000};
        run_and_check(data);

        // dc input lands in bin 0
        for (int i = 0; i < n_points; i++) begin
            data[i] = {16'h1000, 16'h0000};
        end
        run_and_check(data);

        repeat (3) begin
            make_random(data);
            run_and_check(data);
        end

        // loads during a run must not reach the memory
        if (!aborted) begin
            make_random(data);
            load_samples(data);
            expected = fft_ref(data);
            pulse_start();
            inject_loads(12);
            wait_for_done(200);
            compare_bins(200);
        end

        if (!aborted) begin
            check_value("done", done, 32'h1);

            // reset drops the done left by the last run
            rst_n = 1'b0;
            next_cycle();
            check_value("done", done, 32'h0);
            rst_n = 1'b1;
            next_cycle();

            // abort a run with reset and then do a clean run
            make_random(data);
            load_samples(data);
            pulse_start();
            repeat (30) next_cycle();
            rst_n = 1'b0;
            next_cycle();
            next_cycle();
            check_value("busy", busy, 32'h0);
            rst_n = 1'b1;
            next_cycle();
            make_random(data);
            run_and_check(data);
        end

        report_and_finish();
    end

endmodule

`default_nettype wire

/* list.f */
source/fft_pkg.sv
source/fft_mem_if.sv
source/fft_agu.sv
source/fft_twiddle_rom.sv
source/fft_butterfly.sv
source/fft_mem_arbiter.sv
source/fft_dmem.sv
source/fft_top.sv
dv/fft_tb.sv

/* run.sh */
#!/bin/sh
# build the fft testbench with verilator, run it, then scan the log

rm -f sim.log
verilator --binary -Wno-fatal -f list.f --top-module fft_tb -o fft_sim > build.log 2>&1 \
    && ./obj_dir/fft_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation clean"; exit 0; }
